// File: axi_slv_port.f
+incdir+.
axi_slv_port_pkg.sv
axi_chan_fifo.sv
axi_slv_wr_path.sv
axi_slv_rd_path.sv
axi_slv_port.sv
tb_axi_slv_port.sv

// File: tb_axi_slv_port_tasks.svh
//////////////////////////////
// Channel drivers, xorshift and directed tests,
// included inside the testbench module
//////////////////////////////

`ifndef TB_AXI_SLV_PORT_TASKS_SVH
`define TB_AXI_SLV_PORT_TASKS_SVH

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic report_mismatch(input string name, input beat_t exp, input beat_t act);
        mismatches++;
        $display("MISMATCH %s at %0t: expected 0x%0h, got 0x%0h", name, $time, exp, act);
    endtask

    // Only the address channels lose the slave base
    function automatic beat_t expect_beat(input int ch, input beat_t p);
        addr_t offs;
        offs = p[22:7] - SLV_BASE_ADDR;
        case (ch)
            CH_AW, CH_AR: return {15'b0, offs, p[6:0]};
            CH_W:         return {2'b0, p[35:0]};
            CH_B:         return {32'b0, p[5:0]};
            default:      return p;
        endcase
    endfunction

    // Empty B and R queues show zero ID and RESP whatever the stale entry holds
    task automatic check_idle_fields(input int ch);
        if (ch == CH_B && !o_xbar_bvalid && {o_xbar_bid, o_xbar_bresp} !== 6'h0) begin
            report_mismatch("o_xbar_bid/bresp", 38'h0, {o_xbar_bid, o_xbar_bresp});
        end
        if (ch == CH_R && !o_xbar_rvalid && {o_xbar_rid, o_xbar_rresp} !== 6'h0) begin
            report_mismatch("o_xbar_rid/rresp", 38'h0, {o_xbar_rid, o_xbar_rresp});
        end
    endtask

    //////////////////////////////
    // Handshake drivers called on a falling edge
    //////////////////////////////

    task automatic offer(input int ch, input beat_t p, input int stall);
        int t;
        t = 0;
        repeat (stall) @(negedge i_aclk);
        in_beat[ch] = p;
        in_vld[ch]  = 1'b1;
        while (!in_rdy[ch] && t < TIMEOUT) begin
            @(negedge i_aclk);
            t++;
        end
        if (!in_rdy[ch]) begin
            timeouts++;
            $display("Timeout: %s channel input never became ready", ch_name[ch]);
        end
        @(negedge i_aclk);
        in_vld[ch] = 1'b0;
    endtask

    task automatic take(input int ch, input beat_t exp, input int stall);
        int t;
        t = 0;
        repeat (stall) @(negedge i_aclk);
        out_rdy[ch] = 1'b1;
        while (!out_vld[ch] && t < TIMEOUT) begin
            @(negedge i_aclk);
            t++;
        end
        if (!out_vld[ch]) begin
            timeouts++;
            $display("Timeout: %s channel output never became valid", ch_name[ch]);
        end else if (out_beat[ch] !== exp) begin
            report_mismatch(out_name[ch], exp, out_beat[ch]);
        end
        @(negedge i_aclk);
        out_rdy[ch] = 1'b0;
        check_idle_fields(ch);
    endtask

    task automatic feed(input int ch);
        for (int k = 0; k < NRAND; k++) begin
            offer(ch, stim[ch][k], push_stall[ch][k]);
        end
    endtask

    task automatic drain(input int ch);
        for (int k = 0; k < NRAND; k++) begin
            take(ch, expect_beat(ch, stim[ch][k]), pop_stall[ch][k]);
        end
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic test_reset_state();
        if (out_vld !== 5'b0) begin
            report_mismatch("output valids, R B AR W AW", 38'h0, out_vld);
        end
        if (in_rdy !== 5'h1f) begin
            report_mismatch("input readies, R B AR W AW", 38'h1f, in_rdy);
        end
        if ({o_xbar_bid, o_xbar_bresp, o_xbar_rid, o_xbar_rresp} !== 12'h0) begin
            report_mismatch("o_xbar_bid/bresp/rid/rresp", 38'h0,
                            {o_xbar_bid, o_xbar_bresp, o_xbar_rid, o_xbar_rresp});
        end
    endtask

    task automatic test_single_write();
        offer(CH_AW, {15'b0, 16'h4123, 4'h5, 3'h2}, 0);
        offer(CH_W, {2'b0, 32'hcafe_0123, 4'hb}, 0);
        take(CH_AW, {15'b0, 16'h0123, 4'h5, 3'h2}, 0);
        take(CH_W, {2'b0, 32'hcafe_0123, 4'hb}, 0);
        offer(CH_B, {32'b0, 4'h9, 2'h2}, 0);
        take(CH_B, {32'b0, 4'h9, 2'h2}, 0);
        // ID and RESP return to zero once the B queue is empty
        if ({o_xbar_bvalid, o_xbar_bid, o_xbar_bresp} !== 7'h0) begin
            report_mismatch("o_xbar_bvalid/bid/bresp", 38'h0,
                            {o_xbar_bvalid, o_xbar_bid, o_xbar_bresp});
        end
    endtask

    task automatic test_single_read();
        offer(CH_AR, {15'b0, 16'h4abc, 4'ha, 3'h5}, 0);
        take(CH_AR, {15'b0, 16'h0abc, 4'ha, 3'h5}, 0);
        offer(CH_R, {32'h1357_9bdf, 2'h1, 4'h3}, 0);
        take(CH_R, {32'h1357_9bdf, 2'h1, 4'h3}, 0);
        if ({o_xbar_rvalid, o_xbar_rid, o_xbar_rresp} !== 7'h0) begin
            report_mismatch("o_xbar_rvalid/rid/rresp", 38'h0,
                            {o_xbar_rvalid, o_xbar_rid, o_xbar_rresp});
        end
    endtask

    // Only four of five beats fit while the far side is stalled
    task automatic check_backpressure(input int ch, input string rdy_name);
        for (int k = 0; k < 5; k++) begin
            stim[ch][k] = beat_t'(next_rand());
        end
        for (int k = 0; k < 4; k++) begin
            offer(ch, stim[ch][k], 0);
        end
        if (in_rdy[ch] !== 1'b0) begin
            report_mismatch(rdy_name, 38'h0, in_rdy[ch]);
        end
        fork
            offer(ch, stim[ch][4], 0);
            for (int k = 0; k < 5; k++) begin
                take(ch, expect_beat(ch, stim[ch][k]), 0);
            end
        join
    endtask

    task automatic test_random_traffic();
        logic [31:0] r;
        for (int ch = 0; ch < 5; ch++) begin
            for (int k = 0; k < NRAND; k++) begin
                r = next_rand();
                stim[ch][k]       = {r[5:0], next_rand()};
                push_stall[ch][k] = int'(r[9:8]);
                pop_stall[ch][k]  = int'(r[13:12]);
            end
        end
        fork
            feed(CH_AW);
            feed(CH_W);
            feed(CH_AR);
            feed(CH_B);
            feed(CH_R);
            drain(CH_AW);
            drain(CH_W);
            drain(CH_AR);
            drain(CH_B);
            drain(CH_R);
        join
    endtask

`endif

// File: tb_axi_slv_port.sv
//////////////////////////////
// Testbench for the slave port stage, directed tests and
// seeded random traffic on all five channels
//////////////////////////////

`timescale 1ns/100ps

module tb_axi_slv_port;

    import axi_slv_port_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int TIMEOUT    = 200;
    localparam int NRAND      = 40;

    // Channel index, also the bit order of the vectors below
    localparam int CH_AW = 0;
    localparam int CH_W  = 1;
    localparam int CH_AR = 2;
    localparam int CH_B  = 3;
    localparam int CH_R  = 4;

    // Widest payload is R, 38 bits
    typedef logic [37:0] beat_t;

    logic  i_aclk;
    logic  i_arst_n;
    logic  i_xbar_awvalid, o_xbar_awready, i_xbar_wvalid, o_xbar_wready;
    logic  i_xbar_arvalid, o_xbar_arready, o_xbar_bvalid, i_xbar_bready;
    logic  o_xbar_rvalid, i_xbar_rready, o_slv_awvalid, i_slv_awready;
    logic  o_slv_wvalid, i_slv_wready, o_slv_arvalid, i_slv_arready;
    logic  i_slv_bvalid, o_slv_bready, i_slv_rvalid, o_slv_rready;
    addr_t i_xbar_awaddr, i_xbar_araddr, o_slv_awaddr, o_slv_araddr;
    id_t   i_xbar_awid, i_xbar_arid, o_xbar_bid, o_xbar_rid;
    id_t   o_slv_awid, o_slv_arid, i_slv_bid, i_slv_rid;
    prot_t i_xbar_awprot, i_xbar_arprot, o_slv_awprot, o_slv_arprot;
    data_t i_xbar_wdata, o_slv_wdata, o_xbar_rdata, i_slv_rdata;
    strb_t i_xbar_wstrb, o_slv_wstrb;
    resp_t o_xbar_bresp, o_xbar_rresp, i_slv_bresp, i_slv_rresp;

    int          mismatches;
    int          timeouts;
    logic [31:0] rng_state;
    beat_t       stim [5][NRAND];
    int          push_stall [5][NRAND];
    int          pop_stall [5][NRAND];

    string ch_name [5] = '{"AW", "W", "AR", "B", "R"};
    string out_name [5] = '{"o_slv_awaddr/awid/awprot", "o_slv_wdata/wstrb",
                            "o_slv_araddr/arid/arprot", "o_xbar_bid/bresp",
                            "o_xbar_rdata/rresp/rid"};

    //////////////////////////////
    // Channel view
    //////////////////////////////

    logic [4:0]       in_vld;
    logic [4:0]       out_rdy;
    logic [4:0][37:0] in_beat;
    wire  [4:0]       in_rdy;
    wire  [4:0]       out_vld;
    wire  [4:0][37:0] out_beat;

    assign {i_slv_rvalid, i_slv_bvalid, i_xbar_arvalid, i_xbar_wvalid, i_xbar_awvalid} = in_vld;
    assign {i_xbar_rready, i_xbar_bready, i_slv_arready, i_slv_wready, i_slv_awready} = out_rdy;
    assign in_rdy  = {o_slv_rready, o_slv_bready, o_xbar_arready, o_xbar_wready, o_xbar_awready};
    assign out_vld = {o_xbar_rvalid, o_xbar_bvalid, o_slv_arvalid, o_slv_wvalid, o_slv_awvalid};

    // Beats right aligned, fields in struct order
    assign {i_xbar_awaddr, i_xbar_awid, i_xbar_awprot} = in_beat[CH_AW][22:0];
    assign {i_xbar_wdata, i_xbar_wstrb}                = in_beat[CH_W][35:0];
    assign {i_xbar_araddr, i_xbar_arid, i_xbar_arprot} = in_beat[CH_AR][22:0];
    assign {i_slv_bid, i_slv_bresp}                    = in_beat[CH_B][5:0];
    assign {i_slv_rdata, i_slv_rresp, i_slv_rid}       = in_beat[CH_R];

    assign out_beat[CH_AW] = {15'b0, o_slv_awaddr, o_slv_awid, o_slv_awprot};
    assign out_beat[CH_W]  = {2'b0, o_slv_wdata, o_slv_wstrb};
    assign out_beat[CH_AR] = {15'b0, o_slv_araddr, o_slv_arid, o_slv_arprot};
    assign out_beat[CH_B]  = {32'b0, o_xbar_bid, o_xbar_bresp};
    assign out_beat[CH_R]  = {o_xbar_rdata, o_xbar_rresp, o_xbar_rid};

    axi_slv_port i_axi_slv_port (.*);

    initial begin
        i_aclk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) i_aclk = ~i_aclk;
        end
    end

    `include "tb_axi_slv_port_tasks.svh"

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        mismatches = 0;
        timeouts   = 0;
        rng_state  = 32'ha713_612e;
        in_vld     = '0;
        out_rdy    = '0;
        in_beat    = '0;
        i_arst_n   = 1'b0;
        repeat (5) @(negedge i_aclk);
        i_arst_n = 1'b1;
        @(negedge i_aclk);
        test_reset_state();
        test_single_write();
        test_single_read();
        check_backpressure(CH_AW, "o_xbar_awready");
        check_backpressure(CH_B, "o_slv_bready");
        test_random_traffic();
        $display("Run finished: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: axi_slv_port.sv
//////////////////////////////
// Buffered slave-side port of the crossbar, one AXI4-lite slave
//////////////////////////////

`timescale 1ns/100ps

module axi_slv_port (
    input  logic                     i_aclk,
    input  logic                     i_arst_n,
    // Crossbar side, write
    input  logic                     i_xbar_awvalid,
    output logic                     o_xbar_awready,
    input  axi_slv_port_pkg::addr_t  i_xbar_awaddr,
    input  axi_slv_port_pkg::id_t    i_xbar_awid,
    input  axi_slv_port_pkg::prot_t  i_xbar_awprot,
    input  logic                     i_xbar_wvalid,
    output logic                     o_xbar_wready,
    input  axi_slv_port_pkg::data_t  i_xbar_wdata,
    input  axi_slv_port_pkg::strb_t  i_xbar_wstrb,
    output logic                     o_xbar_bvalid,
    input  logic                     i_xbar_bready,
    output axi_slv_port_pkg::id_t    o_xbar_bid,
    output axi_slv_port_pkg::resp_t  o_xbar_bresp,
    // Crossbar side, read
    input  logic                     i_xbar_arvalid,
    output logic                     o_xbar_arready,
    input  axi_slv_port_pkg::addr_t  i_xbar_araddr,
    input  axi_slv_port_pkg::id_t    i_xbar_arid,
    input  axi_slv_port_pkg::prot_t  i_xbar_arprot,
    output logic                     o_xbar_rvalid,
    input  logic                     i_xbar_rready,
    output axi_slv_port_pkg::data_t  o_xbar_rdata,
    output axi_slv_port_pkg::id_t    o_xbar_rid,
    output axi_slv_port_pkg::resp_t  o_xbar_rresp,
    // Slave side, write
    output logic                     o_slv_awvalid,
    input  logic                     i_slv_awready,
    output axi_slv_port_pkg::addr_t  o_slv_awaddr,
    output axi_slv_port_pkg::id_t    o_slv_awid,
    output axi_slv_port_pkg::prot_t  o_slv_awprot,
    output logic                     o_slv_wvalid,
    input  logic                     i_slv_wready,
    output axi_slv_port_pkg::data_t  o_slv_wdata,
    output axi_slv_port_pkg::strb_t  o_slv_wstrb,
    input  logic                     i_slv_bvalid,
    output logic                     o_slv_bready,
    input  axi_slv_port_pkg::id_t    i_slv_bid,
    input  axi_slv_port_pkg::resp_t  i_slv_bresp,
    // Slave side, read
    output logic                     o_slv_arvalid,
    input  logic                     i_slv_arready,
    output axi_slv_port_pkg::addr_t  o_slv_araddr,
    output axi_slv_port_pkg::id_t    o_slv_arid,
    output axi_slv_port_pkg::prot_t  o_slv_arprot,
    input  logic                     i_slv_rvalid,
    output logic                     o_slv_rready,
    input  axi_slv_port_pkg::data_t  i_slv_rdata,
    input  axi_slv_port_pkg::id_t    i_slv_rid,
    input  axi_slv_port_pkg::resp_t  i_slv_rresp
);

    //////////////////////////////
    // Write and read paths
    //////////////////////////////

    // Port names of both paths match the top level one to one
    axi_slv_wr_path wr_path (.*);

    axi_slv_rd_path rd_path (.*);

endmodule

// File: axi_slv_rd_path.sv
//////////////////////////////
// Read side of the slave port: AR and R FIFOs,
// with the slave base address taken off ARADDR
//////////////////////////////

`timescale 1ns/100ps

module axi_slv_rd_path (
    input  logic                     i_aclk,
    input  logic                     i_arst_n,
    // Crossbar side
    input  logic                     i_xbar_arvalid,
    output logic                     o_xbar_arready,
    input  axi_slv_port_pkg::addr_t  i_xbar_araddr,
    input  axi_slv_port_pkg::id_t    i_xbar_arid,
    input  axi_slv_port_pkg::prot_t  i_xbar_arprot,
    output logic                     o_xbar_rvalid,
    input  logic                     i_xbar_rready,
    output axi_slv_port_pkg::data_t  o_xbar_rdata,
    output axi_slv_port_pkg::id_t    o_xbar_rid,
    output axi_slv_port_pkg::resp_t  o_xbar_rresp,
    // Slave side
    output logic                     o_slv_arvalid,
    input  logic                     i_slv_arready,
    output axi_slv_port_pkg::addr_t  o_slv_araddr,
    output axi_slv_port_pkg::id_t    o_slv_arid,
    output axi_slv_port_pkg::prot_t  o_slv_arprot,
    input  logic                     i_slv_rvalid,
    output logic                     o_slv_rready,
    input  axi_slv_port_pkg::data_t  i_slv_rdata,
    input  axi_slv_port_pkg::id_t    i_slv_rid,
    input  axi_slv_port_pkg::resp_t  i_slv_rresp
);

    import axi_slv_port_pkg::*;

    ar_chan_t ar_in;
    ar_chan_t ar_out;
    r_chan_t  r_in;
    r_chan_t  r_out;
    logic     r_valid;

    //////////////////////////////
    // Read address
    //////////////////////////////

    assign ar_in = '{addr: i_xbar_araddr, id: i_xbar_arid, prot: i_xbar_arprot};

    axi_chan_fifo #(.payload_t(ar_chan_t)) ar_fifo (
        .i_aclk   (i_aclk),
        .i_arst_n (i_arst_n),
        .i_valid  (i_xbar_arvalid),
        .i_data   (ar_in),
        .o_ready  (o_xbar_arready),
        .o_valid  (o_slv_arvalid),
        .o_data   (ar_out),
        .i_ready  (i_slv_arready)
    );

    // Same remap as the write address
    assign o_slv_araddr = ar_out.addr - SLV_BASE_ADDR;
    assign o_slv_arid   = ar_out.id;
    assign o_slv_arprot = ar_out.prot;

    //////////////////////////////
    // Read data
    //////////////////////////////

    assign r_in = '{data: i_slv_rdata, resp: i_slv_rresp, id: i_slv_rid};

    axi_chan_fifo #(.payload_t(r_chan_t)) r_fifo (
        .i_aclk   (i_aclk),
        .i_arst_n (i_arst_n),
        .i_valid  (i_slv_rvalid),
        .i_data   (r_in),
        .o_ready  (o_slv_rready),
        .o_valid  (r_valid),
        .o_data   (r_out),
        .i_ready  (i_xbar_rready)
    );

    // Data goes out as stored, ID and RESP zeroed when empty
    assign o_xbar_rvalid = r_valid;
    assign o_xbar_rdata  = r_out.data;
    assign o_xbar_rid    = r_valid ? r_out.id : '0;
    assign o_xbar_rresp  = r_valid ? r_out.resp : '0;

endmodule

// File: axi_slv_wr_path.sv
//////////////////////////////
// Write side of the slave port: AW, W and B FIFOs,
// with the slave base address taken off AWADDR
//////////////////////////////

`timescale 1ns/100ps

module axi_slv_wr_path (
    input  logic                     i_aclk,
    input  logic                     i_arst_n,
    // Crossbar side
    input  logic                     i_xbar_awvalid,
    output logic                     o_xbar_awready,
    input  axi_slv_port_pkg::addr_t  i_xbar_awaddr,
    input  axi_slv_port_pkg::id_t    i_xbar_awid,
    input  axi_slv_port_pkg::prot_t  i_xbar_awprot,
    input  logic                     i_xbar_wvalid,
    output logic                     o_xbar_wready,
    input  axi_slv_port_pkg::data_t  i_xbar_wdata,
    input  axi_slv_port_pkg::strb_t  i_xbar_wstrb,
    output logic                     o_xbar_bvalid,
    input  logic                     i_xbar_bready,
    output axi_slv_port_pkg::id_t    o_xbar_bid,
    output axi_slv_port_pkg::resp_t  o_xbar_bresp,
    // Slave side
    output logic                     o_slv_awvalid,
    input  logic                     i_slv_awready,
    output axi_slv_port_pkg::addr_t  o_slv_awaddr,
    output axi_slv_port_pkg::id_t    o_slv_awid,
    output axi_slv_port_pkg::prot_t  o_slv_awprot,
    output logic                     o_slv_wvalid,
    input  logic                     i_slv_wready,
    output axi_slv_port_pkg::data_t  o_slv_wdata,
    output axi_slv_port_pkg::strb_t  o_slv_wstrb,
    input  logic                     i_slv_bvalid,
    output logic                     o_slv_bready,
    input  axi_slv_port_pkg::id_t    i_slv_bid,
    input  axi_slv_port_pkg::resp_t  i_slv_bresp
);

    import axi_slv_port_pkg::*;

    aw_chan_t aw_in;
    aw_chan_t aw_out;
    w_chan_t  w_in;
    w_chan_t  w_out;
    b_chan_t  b_in;
    b_chan_t  b_out;
    logic     b_valid;

    //////////////////////////////
    // Write address
    //////////////////////////////

    assign aw_in = '{addr: i_xbar_awaddr, id: i_xbar_awid, prot: i_xbar_awprot};

    axi_chan_fifo #(.payload_t(aw_chan_t)) aw_fifo (
        .i_aclk   (i_aclk),
        .i_arst_n (i_arst_n),
        .i_valid  (i_xbar_awvalid),
        .i_data   (aw_in),
        .o_ready  (o_xbar_awready),
        .o_valid  (o_slv_awvalid),
        .o_data   (aw_out),
        .i_ready  (i_slv_awready)
    );

    // Slave sees offsets from its own base, wraps modulo 2^ADDR_W
    assign o_slv_awaddr = aw_out.addr - SLV_BASE_ADDR;
    assign o_slv_awid   = aw_out.id;
    assign o_slv_awprot = aw_out.prot;

    //////////////////////////////
    // Write data
    //////////////////////////////

    assign w_in = '{data: i_xbar_wdata, strb: i_xbar_wstrb};

    axi_chan_fifo #(.payload_t(w_chan_t)) w_fifo (
        .i_aclk   (i_aclk),
        .i_arst_n (i_arst_n),
        .i_valid  (i_xbar_wvalid),
        .i_data   (w_in),
        .o_ready  (o_xbar_wready),
        .o_valid  (o_slv_wvalid),
        .o_data   (w_out),
        .i_ready  (i_slv_wready)
    );

    assign o_slv_wdata = w_out.data;
    assign o_slv_wstrb = w_out.strb;

    //////////////////////////////
    // Write response
    //////////////////////////////

    assign b_in = '{id: i_slv_bid, resp: i_slv_bresp};

    axi_chan_fifo #(.payload_t(b_chan_t)) b_fifo (
        .i_aclk   (i_aclk),
        .i_arst_n (i_arst_n),
        .i_valid  (i_slv_bvalid),
        .i_data   (b_in),
        .o_ready  (o_slv_bready),
        .o_valid  (b_valid),
        .o_data   (b_out),
        .i_ready  (i_xbar_bready)
    );

    // ID and RESP tied low while nothing is queued
    assign o_xbar_bvalid = b_valid;
    assign o_xbar_bid    = b_valid ? b_out.id : '0;
    assign o_xbar_bresp  = b_valid ? b_out.resp : '0;

endmodule

// File: axi_chan_fifo.sv
//////////////////////////////
// Single-clock valid/ready FIFO for one AXI channel,
// payload chosen per instance through payload_t
//////////////////////////////

`timescale 1ns/100ps

module axi_chan_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = axi_slv_port_pkg::OSTD_REQ_NUM
) (
    input  logic     i_aclk,
    input  logic     i_arst_n,
    // Push side
    input  logic     i_valid,
    input  payload_t i_data,
    output logic     o_ready,
    // Pop side
    output logic     o_valid,
    output payload_t o_data,
    input  logic     i_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;

    //////////////////////////////
    // Handshakes
    //////////////////////////////

    assign o_ready = (count != FULL_CNT);
    assign o_valid = (count != '0);

    assign wr_en = i_valid & o_ready;
    assign rd_en = o_valid & i_ready;

    // Head entry is shown as soon as it is written
    assign o_data = mem[rd_ptr];

    //////////////////////////////
    // Storage
    //////////////////////////////

    always_ff @(posedge i_aclk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[wr_ptr] <= i_data;
        end
    end

    //////////////////////////////
    // Pointers and occupancy
    //////////////////////////////

    always_ff @(posedge i_aclk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // Simultaneous push and pop leaves the count unchanged
    always_ff @(posedge i_aclk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            count <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: axi_slv_port_pkg.sv
//////////////////////////////
// Widths, FIFO depth, slave base address and channel payloads
// shared by the slave port stage and its FIFOs
//////////////////////////////

package axi_slv_port_pkg;

    //////////////////////////////
    // Bus widths
    //////////////////////////////

    localparam int ADDR_W = 16;
    localparam int ID_W   = 4;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int PROT_W = 3;
    localparam int RESP_W = 2;

    // Where this slave sits in the crossbar memory map
    localparam logic [ADDR_W-1:0] SLV_BASE_ADDR = 16'h4000;

    // Depth of every channel FIFO
    localparam int OSTD_REQ_NUM = 4;

    //////////////////////////////
    // Field types
    //////////////////////////////

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [ID_W-1:0]   id_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [PROT_W-1:0] prot_t;
    typedef logic [RESP_W-1:0] resp_t;

    //////////////////////////////
    // Channel payloads
    //////////////////////////////

    // Write address, 23 bits
    typedef struct packed {
        addr_t addr;
        id_t   id;
        prot_t prot;
    } aw_chan_t;

    // Read address, same layout as AW
    typedef struct packed {
        addr_t addr;
        id_t   id;
        prot_t prot;
    } ar_chan_t;

    // Write data, 36 bits
    typedef struct packed {
        data_t data;
        strb_t strb;
    } w_chan_t;

    // Write response, 6 bits
    typedef struct packed {
        id_t   id;
        resp_t resp;
    } b_chan_t;

    // Read data, 38 bits
    typedef struct packed {
        data_t data;
        resp_t resp;
        id_t   id;
    } r_chan_t;

endpackage
